// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic              clock,
  input  logic              rst,
  input  pipe_pkg::fetch_t  fetch_in,
  input  logic              inst_valid,
  input  logic              block,
  input  logic              flush,
  output logic [4:0]        rs1,
  output logic [4:0]        rs2,
  input  logic [31:0]       rd1,
  input  logic [31:0]       rd2,
  output logic              ready,
  output pipe_pkg::decode_t dec_out
);
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  logic [xlen-1:0] inst_q;
  logic [xlen-1:0] pc_q;
  logic            valid_q;
  ctrl_t           ctrl;
  logic [xlen-1:0] imm;
  fwd_sel_t        fwd1;
  fwd_sel_t        fwd2;
  logic            accept;

  assign accept = inst_valid && ready;

  always_ff @(posedge clock) begin
    if (rst || flush) begin
      valid_q <= 1'b0;
      inst_q  <= '0;
    end else if (!block) begin
      valid_q <= accept;
      // an empty slot decodes a zero word
      inst_q  <= accept ? fetch_in.inst : '0;
    end
  end

  always_ff @(posedge clock) begin
    if (!block && accept) begin
      pc_q <= fetch_in.pc;
    end
  end

  inst_decoder inst_decoder_inst (
    .inst (inst_q),
    .ctrl (ctrl),
    .imm  (imm),
    .rs1  (rs1),
    .rs2  (rs2)
  );

  hazard_tracker hazard_tracker_inst (
    .clock      (clock),
    .rst        (rst),
    .flush      (flush),
    .block      (block),
    .slot_valid (valid_q),
    .is_load    (ctrl.mem_ren),
    .rd         (ctrl.rd),
    .r_wen      (ctrl.r_wen),
    .rs1        (rs1),
    .rs2        (rs2),
    .ready      (ready),
    .fwd1       (fwd1),
    .fwd2       (fwd2)
  );

  // a bubble carries no enables and no register fields
  always_comb begin
    dec_out       = '0;
    dec_out.valid = valid_q;
    if (valid_q) begin
      dec_out.pc       = pc_q;
      dec_out.ctrl     = ctrl;
      dec_out.imm      = imm;
      dec_out.rs1      = rs1;
      dec_out.rs2      = rs2;
      dec_out.rs1_data = rd1;
      dec_out.rs2_data = rd2;
      dec_out.fwd1     = fwd1;
      dec_out.fwd2     = fwd2;
    end
  end

endmodule

`default_nettype wire

// File: design/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top (
  input  logic              clock,
  input  logic              rst,
  input  pipe_pkg::fetch_t  fetch_in,
  input  logic              inst_valid,
  input  logic              block,
  input  logic              flush,
  input  pipe_pkg::wb_t     wb_in,
  output logic              ready,
  output pipe_pkg::decode_t dec_out
);

  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] rd1;
  logic [31:0] rd2;

  decode_stage decode_stage_inst (
    .clock      (clock),
    .rst        (rst),
    .fetch_in   (fetch_in),
    .inst_valid (inst_valid),
    .block      (block),
    .flush      (flush),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd1        (rd1),
    .rd2        (rd2),
    .ready      (ready),
    .dec_out    (dec_out)
  );

  // writeback enters straight from the last stage
  reg_file reg_file_inst (
    .clock (clock),
    .wb    (wb_in),
    .ra1   (rs1),
    .ra2   (rs2),
    .rd1   (rd1),
    .rd2   (rd2)
  );

endmodule

`default_nettype wire

// File: design/hazard_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_tracker (
  input  logic                    clock,
  input  logic                    rst,
  input  logic                    flush,
  input  logic                    block,
  input  logic                    slot_valid,
  input  logic                    is_load,
  input  logic [4:0]              rd,
  input  logic                    r_wen,
  input  logic [4:0]              rs1,
  input  logic [4:0]              rs2,
  output logic                    ready,
  output rv32i_isa_pkg::fwd_sel_t fwd1,
  output rv32i_isa_pkg::fwd_sel_t fwd2
);
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  // entry 0 is the instruction now in execute, entry 1 the one in memory
  logic [hist_depth-1:0][4:0] hist_rd;
  logic [hist_depth-1:0]      hist_wen;

  function automatic fwd_sel_t match_src(
    input logic [4:0]                 rs,
    input logic [hist_depth-1:0][4:0] h_rd,
    input logic [hist_depth-1:0]      h_wen
  );
    fwd_sel_t sel;
    sel = fwd_none;
    if (rs != 5'd0) begin
      if (h_wen[0] && h_rd[0] == rs) begin
        sel = fwd_from_ex;
      end else if (h_wen[1] && h_rd[1] == rs) begin
        sel = fwd_from_mem;
      end
    end
    return sel;
  endfunction

  always_ff @(posedge clock) begin
    if (rst || flush) begin
      hist_wen <= '0;
    end else if (!block) begin
      hist_wen <= {hist_wen[hist_depth-2:0], slot_valid && r_wen};
    end
  end

  // rd is payload, only meaningful while its enable is set
  always_ff @(posedge clock) begin
    if (!block) begin
      hist_rd <= {hist_rd[hist_depth-2:0], rd};
    end
  end

  assign fwd1 = match_src(rs1, hist_rd, hist_wen);
  assign fwd2 = match_src(rs2, hist_rd, hist_wen);

  // a load in decode holds fetch off for one cycle
  assign ready = !(slot_valid && is_load);

endmodule

`default_nettype wire

// File: design/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
  input  logic [31:0]     inst,
  output pipe_pkg::ctrl_t ctrl,
  output logic [31:0]     imm,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2
);
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'd0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // lui is x0 + imm, csrrw is rs1 + x0
  assign rs1 = (opcode == op_lui) ? 5'd0 : inst[19:15];
  assign rs2 = (opcode == op_system && funct3 == f3_csrrw) ? 5'd0 : inst[24:20];

  always_comb begin
    ctrl         = '0;
    ctrl.alu_op  = alu_add;
    ctrl.opa_sel = opa_reg;
    ctrl.opb_sel = opb_reg;
    ctrl.wb_sel  = wb_alu;
    ctrl.npc_sel = npc_seq;
    imm          = '0;
    case (opcode)
      op_lui: begin
        ctrl.opa_sel = opa_zero;
        ctrl.opb_sel = opb_imm;
        ctrl.r_wen   = 1'b1;
        imm          = imm_u;
      end
      op_auipc: begin
        ctrl.opa_sel = opa_pc;
        ctrl.opb_sel = opb_imm;
        ctrl.r_wen   = 1'b1;
        imm          = imm_u;
      end
      op_jal: begin
        ctrl.opa_sel = opa_pc;
        ctrl.opb_sel = opb_imm;
        ctrl.wb_sel  = wb_pc_plus4;
        ctrl.npc_sel = npc_jal;
        ctrl.r_wen   = 1'b1;
        imm          = imm_j;
      end
      op_jalr: begin
        ctrl.opb_sel = opb_imm;
        ctrl.wb_sel  = wb_pc_plus4;
        ctrl.npc_sel = npc_jalr;
        ctrl.r_wen   = 1'b1;
        ctrl.illegal = (funct3 != f3_jalr);
        imm          = imm_i;
      end
      op_branch: begin
        ctrl.npc_sel = npc_branch;
        imm          = imm_b;
        case (funct3)
          f3_beq:  ctrl.alu_op = alu_eq;
          f3_bne:  ctrl.alu_op = alu_ne;
          f3_blt:  ctrl.alu_op = alu_lt;
          f3_bge:  ctrl.alu_op = alu_ge;
          f3_bltu: ctrl.alu_op = alu_ltu;
          f3_bgeu: ctrl.alu_op = alu_geu;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      op_load: begin
        ctrl.opb_sel = opb_imm;
        ctrl.wb_sel  = wb_mem;
        ctrl.r_wen   = 1'b1;
        ctrl.mem_ren = 1'b1;
        ctrl.size_b  = (funct3 == f3_b) || (funct3 == f3_bu);
        ctrl.size_h  = (funct3 == f3_h) || (funct3 == f3_hu);
        ctrl.sext    = (funct3 == f3_b) || (funct3 == f3_h);
        ctrl.illegal = !(funct3 inside {f3_b, f3_h, f3_w, f3_bu, f3_hu});
        imm          = imm_i;
      end
      op_store: begin
        ctrl.opb_sel = opb_imm;
        ctrl.mem_wen = 1'b1;
        ctrl.size_b  = (funct3 == f3_b);
        ctrl.size_h  = (funct3 == f3_h);
        ctrl.illegal = !(funct3 inside {f3_b, f3_h, f3_w});
        imm          = imm_s;
      end
      op_imm: begin
        ctrl.opb_sel = opb_imm;
        ctrl.r_wen   = 1'b1;
        imm          = imm_i;
        case (funct3)
          f3_add:  ctrl.alu_op = alu_add;
          f3_slt:  ctrl.alu_op = alu_slt;
          f3_sltu: ctrl.alu_op = alu_sltu;
          f3_xor:  ctrl.alu_op = alu_xor;
          f3_or:   ctrl.alu_op = alu_or;
          f3_and:  ctrl.alu_op = alu_and;
          f3_sll: begin
            ctrl.alu_op  = alu_sll;
            ctrl.illegal = (funct7 != f7_base);
          end
          default: begin
            // shift right, funct7 picks logical or arithmetic
            ctrl.alu_op  = (funct7 == f7_alt) ? alu_sra : alu_srl;
            ctrl.illegal = (funct7 != f7_base) && (funct7 != f7_alt);
          end
        endcase
      end
      op_reg: begin
        ctrl.r_wen = 1'b1;
        if (funct7 == f7_alt) begin
          case (funct3)
            f3_add:  ctrl.alu_op = alu_sub;
            f3_sr:   ctrl.alu_op = alu_sra;
            default: ctrl.illegal = 1'b1;
          endcase
        end else if (funct7 == f7_base) begin
          case (funct3)
            f3_add:  ctrl.alu_op = alu_add;
            f3_sll:  ctrl.alu_op = alu_sll;
            f3_slt:  ctrl.alu_op = alu_slt;
            f3_sltu: ctrl.alu_op = alu_sltu;
            f3_xor:  ctrl.alu_op = alu_xor;
            f3_sr:   ctrl.alu_op = alu_srl;
            f3_or:   ctrl.alu_op = alu_or;
            default: ctrl.alu_op = alu_and;
          endcase
        end else begin
          // multiply and divide are not decoded
          ctrl.illegal = 1'b1;
        end
      end
      op_system: begin
        case (funct3)
          f3_priv: begin
            ctrl.ecall   = (inst == sys_ecall);
            ctrl.ebreak  = (inst == sys_ebreak);
            ctrl.mret    = (inst == sys_mret);
            ctrl.illegal = !(ctrl.ecall || ctrl.ebreak || ctrl.mret);
          end
          f3_csrrw, f3_csrrs, f3_csrrc: begin
            ctrl.r_wen    = 1'b1;
            ctrl.csr_wen  = 1'b1;
            ctrl.wb_sel   = wb_csr;
            ctrl.csr_addr = inst[31:20];
            // set and clear combine rs1 with the old csr value
            if (funct3 != f3_csrrw) begin
              ctrl.opb_sel    = opb_csr_mask;
              ctrl.alu_op     = (funct3 == f3_csrrs) ? alu_or : alu_and;
              ctrl.csr_invert = (funct3 == f3_csrrc);
            end
          end
          default: ctrl.illegal = 1'b1;
        endcase
      end
      op_misc_mem: begin
        ctrl.fence_i = (funct3 == f3_fence_i);
        ctrl.illegal = (funct3 != f3_fence_i) && (funct3 != f3_fence);
      end
      default: ctrl.illegal = 1'b1;
    endcase

    if (ctrl.illegal) begin
      ctrl         = '0;
      ctrl.illegal = 1'b1;
      imm          = '0;
    end
    ctrl.rd = ctrl.r_wen ? inst[11:7] : 5'd0;
  end

endmodule

`default_nettype wire

// File: design/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  localparam int xlen       = 32;
  localparam int hist_depth = 2;

  // next-pc source, decided in execute
  localparam logic [1:0] npc_seq    = 2'd0;
  localparam logic [1:0] npc_jal    = 2'd1;
  localparam logic [1:0] npc_jalr   = 2'd2;
  localparam logic [1:0] npc_branch = 2'd3;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } fetch_t;

  typedef struct packed {
    rv32i_isa_pkg::alu_op_t  alu_op;
    rv32i_isa_pkg::opa_sel_t opa_sel;
    rv32i_isa_pkg::opb_sel_t opb_sel;
    logic                    csr_invert;
    rv32i_isa_pkg::wb_sel_t  wb_sel;
    logic [4:0]              rd;
    logic                    r_wen;
    logic                    mem_ren;
    logic                    mem_wen;
    logic                    size_b;
    logic                    size_h;
    logic                    sext;
    logic [1:0]              npc_sel;
    logic [11:0]             csr_addr;
    logic                    csr_wen;
    logic                    ecall;
    logic                    ebreak;
    logic                    mret;
    logic                    fence_i;
    logic                    illegal;
  } ctrl_t;

  typedef struct packed {
    logic                    valid;
    logic [xlen-1:0]         pc;
    ctrl_t                   ctrl;
    logic [xlen-1:0]         imm;
    logic [4:0]              rs1;
    logic [4:0]              rs2;
    logic [xlen-1:0]         rs1_data;
    logic [xlen-1:0]         rs2_data;
    rv32i_isa_pkg::fwd_sel_t fwd1;
    rv32i_isa_pkg::fwd_sel_t fwd2;
  } decode_t;

  typedef struct packed {
    logic            wen;
    logic [4:0]      rd;
    logic [xlen-1:0] data;
  } wb_t;

endpackage

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic          clock,
  input  pipe_pkg::wb_t wb,
  input  logic [4:0]    ra1,
  input  logic [4:0]    ra2,
  output logic [31:0]   rd1,
  output logic [31:0]   rd2
);
  import pipe_pkg::*;

  // x0 has no storage
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clock) begin
    if (wb.wen && wb.rd != 5'd0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // no bypass of a write in the same cycle
  always_comb begin
    if (ra1 == 5'd0) begin
      rd1 = '0;
    end else begin
      rd1 = regs[ra1];
    end
  end

  always_comb begin
    if (ra2 == 5'd0) begin
      rd2 = '0;
    end else begin
      rd2 = regs[ra2];
    end
  end

endmodule

`default_nettype wire

// File: design/rv32i_isa_pkg.sv
`default_nettype none

package rv32i_isa_pkg;

  // major opcodes
  localparam logic [6:0] op_lui      = 7'b01_101_11;
  localparam logic [6:0] op_auipc    = 7'b00_101_11;
  localparam logic [6:0] op_jal      = 7'b11_011_11;
  localparam logic [6:0] op_jalr     = 7'b11_001_11;
  localparam logic [6:0] op_branch   = 7'b11_000_11;
  localparam logic [6:0] op_load     = 7'b00_000_11;
  localparam logic [6:0] op_store    = 7'b01_000_11;
  localparam logic [6:0] op_imm      = 7'b00_100_11;
  localparam logic [6:0] op_reg      = 7'b01_100_11;
  localparam logic [6:0] op_system   = 7'b11_100_11;
  localparam logic [6:0] op_misc_mem = 7'b00_011_11;

  // funct3 for the integer ops, shared by op_imm and op_reg
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // branch compares
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // access size for loads and stores
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;

  localparam logic [2:0] f3_jalr    = 3'b000;
  localparam logic [2:0] f3_priv    = 3'b000;
  localparam logic [2:0] f3_csrrw   = 3'b001;
  localparam logic [2:0] f3_csrrs   = 3'b010;
  localparam logic [2:0] f3_csrrc   = 3'b011;
  localparam logic [2:0] f3_fence   = 3'b000;
  localparam logic [2:0] f3_fence_i = 3'b001;

  localparam logic [6:0] f7_base = 7'b00000_00;
  localparam logic [6:0] f7_alt  = 7'b01000_00;

  // whole instruction words that raise a trap or return from one
  localparam logic [31:0] sys_ecall  = 32'h0000_0073;
  localparam logic [31:0] sys_ebreak = 32'h0010_0073;
  localparam logic [31:0] sys_mret   = 32'h3020_0073;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
  } alu_op_t;

  typedef enum logic [1:0] {opa_reg, opa_pc, opa_zero} opa_sel_t;
  typedef enum logic [1:0] {opb_reg, opb_imm, opb_csr_mask} opb_sel_t;
  typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc_plus4, wb_csr} wb_sel_t;
  typedef enum logic [1:0] {fwd_none, fwd_from_ex, fwd_from_mem} fwd_sel_t;

endpackage

`default_nettype wire

// File: list.f
design/rv32i_isa_pkg.sv
design/pipe_pkg.sv
design/inst_decoder.sv
design/hazard_tracker.sv
design/reg_file.sv
design/decode_stage.sv
design/decode_top.sv
test/decode_tb.sv

// File: run.sh
#!/bin/sh
# build the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module decode_tb -f list.f -o decode_sim \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/decode_sim 2>&1)
echo "$out"
echo "$out" | grep -q "Finished with no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: test/decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_tb;
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  logic    clock;
  logic    rst;
  fetch_t  fetch_in;
  logic    inst_valid;
  logic    block;
  logic    flush;
  wb_t     wb_in;
  logic    ready;
  decode_t dec_out;
  string   test_name;

  decode_top decode_top_inst (
    .clock      (clock),
    .rst        (rst),
    .fetch_in   (fetch_in),
    .inst_valid (inst_valid),
    .block      (block),
    .flush      (flush),
    .wb_in      (wb_in),
    .ready      (ready),
    .dec_out    (dec_out)
  );

  always #50 clock = ~clock;

  // instruction encoders for the base formats
  function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  task automatic check(input string what, input logic [$bits(decode_t)-1:0] expected,
                       input logic [$bits(decode_t)-1:0] actual);
    if (expected !== actual) begin
      $display("Error: %s %s expected %0h actual %0h", test_name, what, expected, actual);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // present one instruction once fetch is allowed and return when it sits in decode
  task automatic issue(input logic [31:0] inst, input logic [31:0] pc);
    int waited;
    waited = 0;
    inst_valid = 1'b0;
    while (!ready && waited < 20) begin
      @(negedge clock);
      waited++;
    end
    if (!ready) begin
      $display("ready never returned within 20 cycles in test %s", test_name);
      $display("Finished with errors");
      $fatal(1);
    end
    fetch_in.inst = inst;
    fetch_in.pc   = pc;
    inst_valid    = 1'b1;
    @(posedge clock);
    @(negedge clock);
  endtask

  task automatic idle(input int cycles);
    inst_valid = 1'b0;
    repeat (cycles) begin
      @(posedge clock);
      @(negedge clock);
    end
  endtask

  task automatic write_reg(input logic [4:0] rd, input logic [31:0] data);
    wb_in.wen  = 1'b1;
    wb_in.rd   = rd;
    wb_in.data = data;
    @(posedge clock);
    @(negedge clock);
    wb_in = '0;
  endtask

  task automatic field_decode();
    logic [11:0] i12;
    logic [19:0] u20;
    logic [20:0] j21;
    logic [12:0] b13;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [31:0] pc;
    test_name = "fields";
    i12 = 12'($urandom);
    u20 = 20'($urandom);
    // keep lui's rs1 field nonzero so the forced zero shows
    u20[3] = 1'b1;
    j21 = {20'($urandom), 1'b0};
    b13 = {12'($urandom), 1'b0};
    rd  = 5'(1 + $urandom % 31);
    ra  = 5'($urandom);
    rb  = 5'($urandom);
    pc  = {30'($urandom), 2'b00};
    idle(2);
    issue(i_type(op_imm, 3'b000, rd, ra, i12), pc);
    check("addi pc", pc, dec_out.pc);
    check("addi imm", {{20{i12[11]}}, i12}, dec_out.imm);
    check("addi rd", rd, dec_out.ctrl.rd);
    check("addi rs1", ra, dec_out.rs1);
    check("addi alu_op", alu_add, dec_out.ctrl.alu_op);
    check("addi opb_sel", opb_imm, dec_out.ctrl.opb_sel);
    check("addi r_wen", 1, dec_out.ctrl.r_wen);
    issue(u_type(u20, rd, op_lui), pc + 4);
    check("lui imm", {u20, 12'h000}, dec_out.imm);
    check("lui rs1", 0, dec_out.rs1);
    check("lui opa_sel", opa_zero, dec_out.ctrl.opa_sel);
    issue(u_type(u20, rd, op_auipc), pc + 8);
    check("auipc imm", {u20, 12'h000}, dec_out.imm);
    check("auipc opa_sel", opa_pc, dec_out.ctrl.opa_sel);
    check("auipc rd", rd, dec_out.ctrl.rd);
    issue(j_type(j21, rd), pc + 12);
    check("jal imm", {{11{j21[20]}}, j21}, dec_out.imm);
    check("jal npc_sel", npc_jal, dec_out.ctrl.npc_sel);
    check("jal wb_sel", wb_pc_plus4, dec_out.ctrl.wb_sel);
    check("jal rd", rd, dec_out.ctrl.rd);
    issue(b_type(b13, rb, ra, 3'b000), pc + 16);
    check("beq imm", {{19{b13[12]}}, b13}, dec_out.imm);
    check("beq alu_op", alu_eq, dec_out.ctrl.alu_op);
    check("beq npc_sel", npc_branch, dec_out.ctrl.npc_sel);
    check("beq rs2", rb, dec_out.rs2);
    check("beq rd", 0, dec_out.ctrl.rd);
    check("beq r_wen", 0, dec_out.ctrl.r_wen);
    issue(s_type(i12, rb, ra, 3'b010), pc + 20);
    check("sw imm", {{20{i12[11]}}, i12}, dec_out.imm);
    check("sw opb_sel", opb_imm, dec_out.ctrl.opb_sel);
    check("sw mem_wen", 1, dec_out.ctrl.mem_wen);
    check("sw r_wen", 0, dec_out.ctrl.r_wen);
    check("sw size", 0, {dec_out.ctrl.size_b, dec_out.ctrl.size_h});
    idle(2);
  endtask

  task automatic register_read();
    logic [31:0] vals [0:31];
    int i;
    test_name = "reg_read";
    idle(2);
    vals[0] = 32'd0;
    for (i = 1; i < 32; i++) begin
      vals[i] = $urandom;
      write_reg(5'(i), vals[i]);
    end
    // x0 must ignore this write
    write_reg(5'd0, $urandom | 32'h1);
    for (i = 1; i < 32; i++) begin
      issue(r_type(f7_base, 5'(32 - i), 5'(i), 3'b000, 5'd0), 32'h100 + 32'(4 * i));
      check("rs1_data", vals[i], dec_out.rs1_data);
      check("rs2_data", vals[32 - i], dec_out.rs2_data);
    end
    issue(r_type(f7_base, 5'd5, 5'd0, 3'b000, 5'd0), 32'h180);
    check("x0 data", 0, dec_out.rs1_data);
    check("x5 data", vals[5], dec_out.rs2_data);
    idle(2);
  endtask

  task automatic forwarding_selects();
    test_name = "forwarding";
    idle(2);
    issue(i_type(op_imm, 3'b000, 5'd7, 5'd1, 12'h011), 32'h200);
    issue(r_type(f7_base, 5'd0, 5'd7, 3'b000, 5'd8), 32'h204);
    check("back to back fwd1", fwd_from_ex, dec_out.fwd1);
    check("x0 fwd2", fwd_none, dec_out.fwd2);
    // x8 is now one slot older than x9
    issue(i_type(op_imm, 3'b000, 5'd9, 5'd1, 12'h022), 32'h208);
    issue(r_type(f7_base, 5'd8, 5'd2, 3'b000, 5'd10), 32'h20c);
    check("one between fwd2", fwd_from_mem, dec_out.fwd2);
    check("unrelated fwd1", fwd_none, dec_out.fwd1);
    issue(i_type(op_imm, 3'b000, 5'd0, 5'd1, 12'h033), 32'h210);
    issue(r_type(f7_base, 5'd0, 5'd0, 3'b000, 5'd11), 32'h214);
    check("x0 fwd1", fwd_none, dec_out.fwd1);
    idle(2);
  endtask

  task automatic load_use_bubble();
    logic [11:0] i12;
    test_name = "load_use";
    i12 = 12'($urandom);
    idle(2);
    issue(i_type(op_load, 3'b010, 5'd9, 5'd2, i12), 32'h500);
    check("lw mem_ren", 1, dec_out.ctrl.mem_ren);
    check("lw imm", {{20{i12[11]}}, i12}, dec_out.imm);
    check("lw wb_sel", wb_mem, dec_out.ctrl.wb_sel);
    check("lw ready", 0, ready);
    // fetch already holds the dependent add while the load sits in decode
    fetch_in.inst = r_type(f7_base, 5'd3, 5'd9, 3'b000, 5'd10);
    fetch_in.pc   = 32'h504;
    inst_valid    = 1'b1;
    @(posedge clock);
    @(negedge clock);
    check("bubble valid", 0, dec_out.valid);
    check("bubble ready", 1, ready);
    issue(r_type(f7_base, 5'd3, 5'd9, 3'b000, 5'd10), 32'h504);
    check("use valid", 1, dec_out.valid);
    check("use pc", 32'h504, dec_out.pc);
    check("use rs1", 9, dec_out.rs1);
    check("use rd", 10, dec_out.ctrl.rd);
    check("use fwd1", fwd_from_mem, dec_out.fwd1);
    idle(2);
  endtask

  task automatic block_and_flush();
    decode_t held;
    int i;
    test_name = "block_flush";
    idle(2);
    issue(i_type(op_imm, 3'b000, 5'd12, 5'd1, 12'h7f0), 32'h300);
    held = dec_out;
    check("held valid", 1, held.valid);
    // fetch offers the next instruction while the stage is blocked
    block         = 1'b1;
    fetch_in.inst = i_type(op_imm, 3'b000, 5'd13, 5'd1, 12'h001);
    fetch_in.pc   = 32'h304;
    inst_valid    = 1'b1;
    for (i = 0; i < 4; i++) begin
      @(posedge clock);
      @(negedge clock);
      check("held bundle", held, dec_out);
    end
    block = 1'b0;
    issue(i_type(op_imm, 3'b000, 5'd13, 5'd1, 12'h001), 32'h304);
    check("released pc", 32'h304, dec_out.pc);
    // fetch keeps offering an instruction that the flush must refuse
    flush         = 1'b1;
    fetch_in.inst = i_type(op_imm, 3'b000, 5'd15, 5'd1, 12'h002);
    fetch_in.pc   = 32'h308;
    inst_valid    = 1'b1;
    @(posedge clock);
    @(negedge clock);
    flush = 1'b0;
    check("flush valid", 0, dec_out.valid);
    issue(r_type(f7_base, 5'd0, 5'd13, 3'b000, 5'd14), 32'h30c);
    check("flush rs1", 13, dec_out.rs1);
    check("flush fwd1", fwd_none, dec_out.fwd1);
    idle(2);
  endtask

  task automatic system_decode();
    logic [24:0] junk;
    test_name = "system";
    junk = 25'($urandom);
    idle(2);
    issue(32'h0000_0073, 32'h400);
    check("ecall flag", 1, dec_out.ctrl.ecall);
    check("ecall illegal", 0, dec_out.ctrl.illegal);
    issue(32'h3020_0073, 32'h404);
    check("mret flag", 1, dec_out.ctrl.mret);
    issue(i_type(op_misc_mem, 3'b001, 5'd0, 5'd0, 12'h000), 32'h408);
    check("fence_i flag", 1, dec_out.ctrl.fence_i);
    // csrrs x5, mstatus, x6
    issue(i_type(op_system, 3'b010, 5'd5, 5'd6, 12'h300), 32'h40c);
    check("csrrs csr_addr", 12'h300, dec_out.ctrl.csr_addr);
    check("csrrs csr_wen", 1, dec_out.ctrl.csr_wen);
    check("csrrs rd", 5, dec_out.ctrl.rd);
    check("csrrs wb_sel", wb_csr, dec_out.ctrl.wb_sel);
    check("csrrs alu_op", alu_or, dec_out.ctrl.alu_op);
    issue({junk, 7'b111_1111}, 32'h410);
    check("unknown illegal", 1, dec_out.ctrl.illegal);
    check("unknown enables", 0,
          {dec_out.ctrl.r_wen, dec_out.ctrl.mem_ren, dec_out.ctrl.mem_wen});
    idle(2);
  endtask

  initial begin
    void'($urandom(32'h96ea_0edb));
    clock      = 1'b0;
    rst        = 1'b1;
    fetch_in   = '0;
    inst_valid = 1'b0;
    block      = 1'b0;
    flush      = 1'b0;
    wb_in      = '0;
    test_name  = "reset";
    repeat (16) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
    check("valid", 0, dec_out.valid);
    check("ready", 1, ready);
    field_decode();
    register_read();
    forwarding_selects();
    load_use_bubble();
    block_and_flush();
    system_decode();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire
